/* verilog.f */
src/sdhub_pkg.sv
src/reset_stretch.sv
src/sd_host_mux.sv
src/spi_byte_engine.sv
src/sdhub_top.sv
testbench/sdhub_assertions.sv
testbench/tb_sdhub.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sdhub
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed
PASS_MSG  = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* testbench/tb_sdhub.sv */
////////////////////////////////////////
// SD hub testbench: LFSR stimulus,
// SD card model, reference model, checks
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_sdhub;

	import sdhub_pkg::*;

	localparam int XFER_CYCLES = 2 * DEF_SPI_HALF * SD_BITS;

	logic     fclk;
	logic     rst_n;
	logic     avr_genrst;
	logic     avr_lock_claim;
	logic     avr_sdcs_n;
	logic     avr_sd_start;
	sd_byte_t avr_sd_datain;
	logic     zx_sdcs_n_val;
	logic     zx_sdcs_n_stb;
	logic     zx_sd_start;
	sd_byte_t zx_sd_datain;
	logic     sddi;
	logic     avr_lock_grant;
	logic     sdcs_n;
	logic     sdclk;
	logic     sddo;
	logic     sd_busy;
	sd_byte_t sd_rxbyte;

	// reference model state
	host_e       exp_owner;
	logic        exp_zx_cs;
	sd_byte_t    exp_rx;
	sd_byte_t    card_reply;
	sd_byte_t    card_rx;
	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	int          test_no;
	int          err_base;

	sdhub_top i_sdhub_top (
		.fclk          (fclk          ),
		.rst_n         (rst_n         ),
		.avr_genrst    (avr_genrst    ),
		.avr_lock_claim(avr_lock_claim),
		.avr_lock_grant(avr_lock_grant),
		.avr_sdcs_n    (avr_sdcs_n    ),
		.avr_sd_start  (avr_sd_start  ),
		.avr_sd_datain (avr_sd_datain ),
		.zx_sdcs_n_val (zx_sdcs_n_val ),
		.zx_sdcs_n_stb (zx_sdcs_n_stb ),
		.zx_sd_start   (zx_sd_start   ),
		.zx_sd_datain  (zx_sd_datain  ),
		.sdcs_n        (sdcs_n        ),
		.sdclk         (sdclk         ),
		.sddo          (sddo          ),
		.sddi          (sddi          ),
		.sd_busy       (sd_busy       ),
		.sd_rxbyte     (sd_rxbyte     )
	);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	////////////////////////////////////////
	// SD card model
	////////////////////////////////////////

	// reply loaded as busy rises, next bit after each falling sdclk
	initial
	begin : card_model
		int card_bits;
		sddi    = 1'b1;
		card_rx = '0;
		forever
		begin
			@(posedge sd_busy);
			card_bits = 0;
			card_rx   = '0;
			sddi      = card_reply[SD_BITS-1];
			while (sd_busy && card_bits < SD_BITS)
			begin
				@(posedge sdclk or negedge sd_busy);
				if (sd_busy)
				begin
					if (!sdcs_n)
					begin
						card_rx = {card_rx[SD_BITS-2:0], sddo};
					end
					@(negedge sdclk or negedge sd_busy);
					card_bits++;
					#1;
					if (card_bits < SD_BITS)
					begin
						sddi = card_reply[SD_BITS-1-card_bits];
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic sd_byte_t rand_byte();
		sd_byte_t b;
		b = '0;
		for (int i = 0; i < SD_BITS; i++)
		begin
			b = {b[SD_BITS-2:0], rand_bit()};
		end
		return b;
	endfunction

	task automatic tick();
		@(posedge fclk);
		#1;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic expect_seen(input logic seen, input string what);
		checks++;
		assert (seen)
		else
		begin
			$display("timeout at %0t: no %s", $time, what);
			errors++;
		end
	endtask

	task automatic expect_absent(input logic seen, input string what);
		checks++;
		assert (!seen)
		else
		begin
			$display("unexpected %s at %0t", what, $time);
			errors++;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit, output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < limit)
		begin
			@(negedge fclk);
			seen = (sd_busy === level);
			n++;
		end
	endtask

	task automatic wait_grant(input logic level, input int limit, output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < limit)
		begin
			@(negedge fclk);
			seen = (avr_lock_grant === level);
			n++;
		end
	endtask

	task automatic pulse_start(input host_e host, input sd_byte_t data);
		tick();
		if (host == host_avr)
		begin
			avr_sd_start  = 1'b1;
			avr_sd_datain = data;
		end
		else
		begin
			zx_sd_start  = 1'b1;
			zx_sd_datain = data;
		end
		tick();
		avr_sd_start = 1'b0;
		zx_sd_start  = 1'b0;
	endtask

	task automatic strobe_zx_cs(input logic val);
		tick();
		zx_sdcs_n_val = val;
		zx_sdcs_n_stb = 1'b1;
		tick();
		zx_sdcs_n_stb = 1'b0;
		exp_zx_cs     = val;
	endtask

	task automatic set_claim(input logic level);
		logic seen;
		tick();
		avr_lock_claim = level;
		wait_grant(level, 8, seen);
		expect_seen(seen, "avr_lock_grant change after the claim changed");
		exp_owner = level ? host_avr : host_zx;
	endtask

	task automatic check_cs();
		@(negedge fclk);
		check_value("sdcs_n", 32'(sdcs_n),
			(exp_owner == host_avr) ? 32'(avr_sdcs_n) : 32'(exp_zx_cs));
	endtask

	// one byte, optionally with a second start while busy
	task automatic transfer(input host_e host, input logic extra_start);
		sd_byte_t data;
		sd_byte_t reply;
		logic     seen;
		time      t_rise;
		time      t_fall;
		data       = rand_byte();
		reply      = rand_byte();
		card_reply = reply;
		pulse_start(host, data);
		wait_busy(1'b1, 4, seen);
		expect_seen(seen, "sd_busy rise after an accepted start");
		t_rise = $time;
		if (extra_start)
		begin
			pulse_start(host, rand_byte());
		end
		wait_busy(1'b0, 4 * XFER_CYCLES, seen);
		expect_seen(seen, "sd_busy fall at the end of the transfer");
		t_fall = $time;
		check_value("busy cycles", 32'((t_fall - t_rise) / 10), XFER_CYCLES);
		check_value("sd_rxbyte", 32'(sd_rxbyte), 32'(reply));
		check_value("byte seen by the card", 32'(card_rx), 32'(data));
		exp_rx = reply;
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s: %s", test_no, name, (errors == err_base) ? "ok" : "errors");
		test_no++;
		err_base = errors;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin : main
		logic seen;
		int   n;
		rst_n          = 1'b0;
		avr_genrst     = 1'b0;
		avr_lock_claim = 1'b0;
		avr_sdcs_n     = 1'b1;
		avr_sd_start   = 1'b0;
		avr_sd_datain  = '0;
		zx_sdcs_n_val  = 1'b1;
		zx_sdcs_n_stb  = 1'b0;
		zx_sd_start    = 1'b0;
		zx_sd_datain   = '0;
		lfsr_state     = 32'h52be;
		card_reply     = 8'hff;
		exp_owner      = host_zx;
		exp_zx_cs      = 1'b1;
		exp_rx         = 8'hff;
		errors         = 0;
		checks         = 0;
		test_no        = 0;
		err_base       = 0;

		repeat (16) @(posedge fclk);
		#1 rst_n = 1'b1;
		// stretched hub reset first, then the idle state
		seen = 1'b0;
		n    = 0;
		while (!seen && n < 200)
		begin
			@(negedge fclk);
			seen = (i_sdhub_top.hub_rst_n === 1'b1) && !sd_busy && sdcs_n;
			n++;
		end
		expect_seen(seen, "idle hub after reset");
		check_value("sdclk", 32'(sdclk), 0);
		check_value("sd_busy", 32'(sd_busy), 0);
		check_value("avr_lock_grant", 32'(avr_lock_grant), 0);
		check_value("sddo", 32'(sddo), 1);
		check_value("sd_rxbyte", 32'(sd_rxbyte), 32'(exp_rx));
		check_cs();
		finish_test("reset state");

		strobe_zx_cs(1'b0);
		check_cs();
		for (int i = 0; i < 4; i++)
		begin
			transfer(host_zx, 1'b0);
		end
		finish_test("z80 transfer");

		// claim raised in the middle of a byte, grant waits for idle
		card_reply = rand_byte();
		pulse_start(host_zx, rand_byte());
		wait_busy(1'b1, 4, seen);
		expect_seen(seen, "sd_busy rise before the claim");
		tick();
		avr_lock_claim = 1'b1;
		n = 0;
		while (sd_busy && n < 4 * XFER_CYCLES)
		begin
			@(negedge fclk);
			if (sd_busy)
			begin
				check_value("avr_lock_grant while busy", 32'(avr_lock_grant), 0);
			end
			n++;
		end
		seen = !sd_busy;
		expect_seen(seen, "sd_busy fall with the claim pending");
		check_value("sd_rxbyte", 32'(sd_rxbyte), 32'(card_reply));
		exp_rx = card_reply;
		wait_grant(1'b1, 8, seen);
		expect_seen(seen, "avr_lock_grant after the byte in flight");
		exp_owner = host_avr;
		tick();
		avr_sdcs_n = 1'b0;
		check_cs();
		for (int i = 0; i < 3; i++)
		begin
			transfer(host_avr, 1'b0);
		end
		tick();
		avr_sdcs_n = 1'b1;
		check_cs();
		set_claim(1'b0);
		check_cs();
		finish_test("lock handover");

		pulse_start(host_avr, rand_byte());
		wait_busy(1'b1, 20, seen);
		expect_absent(seen, "sd_busy from the host without the card");
		transfer(host_zx, 1'b1);
		wait_busy(1'b1, 20, seen);
		expect_absent(seen, "sd_busy from a start sent while busy");
		check_value("sd_rxbyte", 32'(sd_rxbyte), 32'(exp_rx));
		finish_test("ignored starts");

		set_claim(1'b1);
		tick();
		avr_sdcs_n = 1'b0;
		strobe_zx_cs(1'b1);
		check_cs();
		set_claim(1'b0);
		check_cs();
		strobe_zx_cs(1'b0);
		check_cs();
		finish_test("chip-select register");

		set_claim(1'b1);
		tick();
		avr_sdcs_n = 1'b0;
		card_reply = rand_byte();
		pulse_start(host_avr, rand_byte());
		wait_busy(1'b1, 4, seen);
		expect_seen(seen, "sd_busy rise before the host reset");
		repeat (5) tick();
		avr_genrst = 1'b1;
		tick();
		avr_genrst = 1'b0;
		// hub reset puts the model back to its reset state
		exp_owner = host_zx;
		exp_zx_cs = 1'b1;
		exp_rx    = 8'hff;
		@(negedge fclk);
		check_value("sdclk", 32'(sdclk), 0);
		check_value("sd_busy", 32'(sd_busy), 0);
		check_value("avr_lock_grant", 32'(avr_lock_grant), 0);
		check_value("sd_rxbyte", 32'(sd_rxbyte), 32'(exp_rx));
		check_value("sdcs_n", 32'(sdcs_n), 1);
		// claim stays high, the lock must wait for the release
		seen = 1'b0;
		n    = 0;
		while (!seen && n < 200)
		begin
			@(negedge fclk);
			if (i_sdhub_top.hub_rst_n === 1'b1)
			begin
				seen = 1'b1;
			end
			else
			begin
				check_value("avr_lock_grant in hub reset", 32'(avr_lock_grant), 0);
			end
			n++;
		end
		expect_seen(seen, "release of the hub reset after avr_genrst");
		wait_grant(1'b1, 8, seen);
		expect_seen(seen, "avr_lock_grant after the hub reset");
		exp_owner = host_avr;
		check_cs();
		tick();
		avr_sdcs_n = 1'b1;
		set_claim(1'b0);
		check_cs();
		finish_test("host reset");

		errors += i_sdhub_top.i_sdhub_assertions.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
		if (errors == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/sdhub_assertions.sv */
////////////////////////////////////////
// SPI protocol assertions for the SD hub,
// bound to the top level
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdhub_assertions #(
	parameter int SPI_HALF = sdhub_pkg::DEF_SPI_HALF
) (
	input logic fclk,
	input logic hub_rst_n,
	input logic sd_busy,
	input logic sdclk,
	input logic avr_lock_grant
);

	import sdhub_pkg::*;

	localparam int XFER_CYCLES = 2 * SPI_HALF * SD_BITS;

	// failures seen, read by the testbench at the end
	int fail_cnt = 0;

	// mode 0, clock parked low between bytes
	sdclk_idle_low: assert property (@(posedge fclk) disable iff (!hub_rst_n)
		!sd_busy |-> !sdclk)
	else
	begin
		$error("sdclk high while the engine is idle");
		fail_cnt++;
	end

	// ownership moves only between bytes
	grant_when_idle: assert property (@(posedge fclk) disable iff (!hub_rst_n)
		$changed(avr_lock_grant) |-> !$past(sd_busy))
	else
	begin
		$error("avr_lock_grant changed during a transfer");
		fail_cnt++;
	end

	busy_length: assert property (@(posedge fclk) disable iff (!hub_rst_n)
		$rose(sd_busy) |-> sd_busy[*XFER_CYCLES] ##1 !sd_busy)
	else
	begin
		$error("sd_busy pulse has the wrong length");
		fail_cnt++;
	end

endmodule

bind sdhub_top sdhub_assertions #(
	.SPI_HALF(SPI_HALF)
) i_sdhub_assertions (
	.fclk          (fclk          ),
	.hub_rst_n     (hub_rst_n     ),
	.sd_busy       (sd_busy       ),
	.sdclk         (sdclk         ),
	.avr_lock_grant(avr_lock_grant)
);

`default_nettype wire

/* src/sdhub_top.sv */
////////////////////////////////////////
// SD hub top level: reset stretcher,
// host mux and SPI byte engine
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sdhub_top #(
	parameter int RST_CNT_SIZE = sdhub_pkg::DEF_RST_CNT_SIZE,
	parameter int SPI_HALF     = sdhub_pkg::DEF_SPI_HALF
) (
	input  logic               fclk,
	input  logic               rst_n,

	// AVR side
	input  logic               avr_genrst,
	input  logic               avr_lock_claim,
	output logic               avr_lock_grant,
	input  logic               avr_sdcs_n,
	input  logic               avr_sd_start,
	input  sdhub_pkg::sd_byte_t avr_sd_datain,

	// Z80 port side
	input  logic               zx_sdcs_n_val,
	input  logic               zx_sdcs_n_stb,
	input  logic               zx_sd_start,
	input  sdhub_pkg::sd_byte_t zx_sd_datain,

	// card pins
	output logic               sdcs_n,
	output logic               sdclk,
	output logic               sddo,
	input  logic               sddi,

	// shared status and result
	output logic               sd_busy,
	output sdhub_pkg::sd_byte_t sd_rxbyte
);

	import sdhub_pkg::*;

	logic     hub_rst_n;
	logic     spi_start;
	sd_byte_t spi_txbyte;

	reset_stretch #(
		.RST_CNT_SIZE(RST_CNT_SIZE)
	) i_reset_stretch (
		.fclk      (fclk      ),
		.rst_n     (rst_n     ),
		.avr_genrst(avr_genrst),
		.hub_rst_n (hub_rst_n )
	);

	sd_host_mux i_sd_host_mux (
		.fclk          (fclk          ),
		.hub_rst_n     (hub_rst_n     ),
		.avr_lock_claim(avr_lock_claim),
		.avr_lock_grant(avr_lock_grant),
		.avr_sdcs_n    (avr_sdcs_n    ),
		.avr_sd_start  (avr_sd_start  ),
		.avr_sd_datain (avr_sd_datain ),
		.zx_sdcs_n_val (zx_sdcs_n_val ),
		.zx_sdcs_n_stb (zx_sdcs_n_stb ),
		.zx_sd_start   (zx_sd_start   ),
		.zx_sd_datain  (zx_sd_datain  ),
		.sdcs_n        (sdcs_n        ),
		.busy          (sd_busy       ),
		.spi_start     (spi_start     ),
		.spi_txbyte    (spi_txbyte    )
	);

	spi_byte_engine #(
		.SPI_HALF(SPI_HALF)
	) i_spi_byte_engine (
		.fclk      (fclk      ),
		.hub_rst_n (hub_rst_n ),
		.spi_start (spi_start ),
		.spi_txbyte(spi_txbyte),
		.sdclk     (sdclk     ),
		.sddo      (sddo      ),
		.sddi      (sddi      ),
		.busy      (sd_busy   ),
		.sd_rxbyte (sd_rxbyte )
	);

endmodule

`default_nettype wire

/* src/spi_byte_engine.sv */
////////////////////////////////////////
// SPI mode 0 byte engine: sdclk pacing,
// tx/rx shifters, busy and result byte
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module spi_byte_engine #(
	parameter int SPI_HALF = sdhub_pkg::DEF_SPI_HALF
) (
	input  logic               fclk,
	input  logic               hub_rst_n,

	// from the input side
	input  logic               spi_start,
	input  sdhub_pkg::sd_byte_t spi_txbyte,

	// SD card pins
	output logic               sdclk,
	output logic               sddo,
	input  logic               sddi,

	// status and result towards both hosts
	output logic               busy,
	output sdhub_pkg::sd_byte_t sd_rxbyte
);

	import sdhub_pkg::*;

	localparam int HALF_W = (SPI_HALF > 1) ? $clog2(SPI_HALF) : 1;
	localparam int BIT_W  = $clog2(SD_BITS);

	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SPI_HALF - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(SD_BITS - 1);

	logic [HALF_W-1:0] half_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	logic              half_end;
	sd_byte_t          tx_shift;
	sd_byte_t          rx_shift;

	assign half_end = (half_cnt == HALF_LAST);

	////////////////////////////////////////
	// control: busy, sdclk and counters
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge hub_rst_n)
	begin
		if (!hub_rst_n)
		begin
			busy      <= 1'b0;
			sdclk     <= 1'b0;
			half_cnt  <= '0;
			bit_cnt   <= '0;
			sd_rxbyte <= '1;
		end
		else if (!busy)
		begin
			// input side guarantees no start while busy
			if (spi_start)
			begin
				busy     <= 1'b1;
				half_cnt <= '0;
				bit_cnt  <= '0;
			end
		end
		else if (!half_end)
		begin
			half_cnt <= half_cnt + 1'b1;
		end
		else
		begin
			half_cnt <= '0;
			sdclk    <= ~sdclk;
			if (sdclk)
			begin
				// falling edge closes a bit
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == BIT_LAST)
				begin
					busy      <= 1'b0;
					sd_rxbyte <= rx_shift;
				end
			end
		end
	end

	////////////////////////////////////////
	// data shifters
	////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!busy && spi_start)
		begin
			tx_shift <= spi_txbyte;
		end
		else if (busy && half_end)
		begin
			if (!sdclk)
			begin
				// sample on the rising sdclk
				rx_shift <= {rx_shift[SD_BITS-2:0], sddi};
			end
			else
			begin
				tx_shift <= {tx_shift[SD_BITS-2:0], 1'b0};
			end
		end
	end

	// MSB first, line idles high
	assign sddo = busy ? tx_shift[SD_BITS-1] : 1'b1;

endmodule

`default_nettype wire

/* src/sd_host_mux.sv */
////////////////////////////////////////
// SD hub input side: lock arbiter, Z80 cs
// register, per-owner start and byte select
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module sd_host_mux (
	input  logic               fclk,
	input  logic               hub_rst_n,

	// AVR side
	input  logic               avr_lock_claim,
	output logic               avr_lock_grant,
	input  logic               avr_sdcs_n,
	input  logic               avr_sd_start,
	input  sdhub_pkg::sd_byte_t avr_sd_datain,

	// Z80 port side
	input  logic               zx_sdcs_n_val,
	input  logic               zx_sdcs_n_stb,
	input  logic               zx_sd_start,
	input  sdhub_pkg::sd_byte_t zx_sd_datain,

	// towards the card and the engine
	output logic               sdcs_n,
	input  logic               busy,
	output logic               spi_start,
	output sdhub_pkg::sd_byte_t spi_txbyte
);

	import sdhub_pkg::*;

	host_e    owner;
	logic     zx_sdcs_n;
	logic     eng_active;
	logic     sel_start;
	sd_byte_t sel_datain;

	// a start already issued counts as busy for one more cycle,
	// the engine raises busy only on the edge after spi_start
	assign eng_active = busy | spi_start;

	////////////////////////////////////////
	// lock arbiter
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge hub_rst_n)
	begin
		if (!hub_rst_n)
		begin
			owner <= host_zx;
		end
		else if (!eng_active)
		begin
			owner <= avr_lock_claim ? host_avr : host_zx;
		end
	end

	assign avr_lock_grant = (owner == host_avr);

	////////////////////////////////////////
	// Z80 chip select register
	////////////////////////////////////////

	// loaded whoever owns the card
	always_ff @(posedge fclk or negedge hub_rst_n)
	begin
		if (!hub_rst_n)
		begin
			zx_sdcs_n <= 1'b1;
		end
		else if (zx_sdcs_n_stb)
		begin
			zx_sdcs_n <= zx_sdcs_n_val;
		end
	end

	assign sdcs_n = (owner == host_avr) ? avr_sdcs_n : zx_sdcs_n;

	////////////////////////////////////////
	// start and byte selection
	////////////////////////////////////////

	// the other host's strobes never get through
	assign sel_start  = (owner == host_avr) ? avr_sd_start  : zx_sd_start;
	assign sel_datain = (owner == host_avr) ? avr_sd_datain : zx_sd_datain;

	always_ff @(posedge fclk or negedge hub_rst_n)
	begin
		if (!hub_rst_n)
		begin
			spi_start <= 1'b0;
		end
		else
		begin
			// dropped silently while a byte is in flight
			spi_start <= sel_start & ~eng_active;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (sel_start && !eng_active)
		begin
			spi_txbyte <= sel_datain;
		end
	end

endmodule

`default_nettype wire

/* src/reset_stretch.sv */
////////////////////////////////////////
// reset stretcher for the SD hub
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module reset_stretch #(
	parameter int RST_CNT_SIZE = sdhub_pkg::DEF_RST_CNT_SIZE
) (
	input  logic fclk,
	input  logic rst_n,
	input  logic avr_genrst,
	output logic hub_rst_n
);

	// one extra bit, the top one marks the end of the stretch
	logic [RST_CNT_SIZE:0] rst_cnt;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_cnt <= '0;
		end
		else if (avr_genrst)
		begin
			// host request restarts the whole stretch
			rst_cnt <= '0;
		end
		else if (!rst_cnt[RST_CNT_SIZE])
		begin
			rst_cnt <= rst_cnt + 1'b1;
		end
	end

	// counter stops once the top bit is set, so release holds
	assign hub_rst_n = rst_cnt[RST_CNT_SIZE];

endmodule

`default_nettype wire

/* src/sdhub_pkg.sv */
////////////////////////////////////////
// SD hub package: byte and owner types,
// default parameter values
////////////////////////////////////////

`default_nettype none

package sdhub_pkg;

	// one byte on the SD SPI wires
	typedef logic [7:0] sd_byte_t;

	// current owner of the card
	typedef enum logic
	{
		host_zx  = 1'b0,
		host_avr = 1'b1
	} host_e;

	// reset stretch counter width, 2^6 = 64 cycles
	localparam int DEF_RST_CNT_SIZE = 6;

	// fclk cycles per sdclk half-period
	localparam int DEF_SPI_HALF = 1;

	// bits per transfer
	localparam int SD_BITS = 8;

endpackage

`default_nettype wire
